//--- filelist.f
icache_pkg.sv
icache_data_array.sv
icache_tag_match.sv
icache_way_select.sv
icache_diag_counter.sv
icache_diag_ctrl.sv
icache_top.sv
tb_icache.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the icache testbench with Verilator, run it, decide from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_icache -f filelist.f -o sim_icache
# simulator exits non-zero on $fatal, the log decides the result
./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation finished: FAIL" sim.log; then
   echo "result: fail"
   exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
   echo "result: no pass message in log"
   exit 1
fi
echo "result: pass"

//--- tb_icache.sv
// assumes 8 sets and 10-bit tags; tags stay unique per set and every entry is filled before the walk
`timescale 1ns/1ps

module tb_icache;

   localparam int INDEX_W = 3;
   localparam int TAG_W   = 10;
   localparam int N_ENT   = 32;
   localparam int N_TBL   = 12;

   logic                             rclk;
   logic                             reset;
   logic                             fill_valid;
   logic [INDEX_W-1:0]               fill_index;
   logic [icache_pkg::WAY_SEL_W-1:0] fill_way;
   logic [TAG_W-1:0]                 fill_tag;
   logic [icache_pkg::WAY_W-1:0]     fill_fet;
   logic [icache_pkg::WAY_W-1:0]     fill_top;
   logic                             fetch_req;
   logic [INDEX_W-1:0]               fetch_index;
   logic [TAG_W-1:0]                 fetch_tag;
   logic                             diag_start;
   logic                             fetch_valid;
   logic                             fetch_hit;
   logic [icache_pkg::WAY_W-1:0]     fetch_fet;
   logic [icache_pkg::WAY_W-1:0]     fetch_top;
   logic                             diag_valid;
   logic [icache_pkg::DIAG_W-1:0]    diag_data;
   logic                             diag_done;
   logic                             diag_busy;

   // reference model indexed by set*4 + way
   logic [33:0] m_fet [N_ENT];
   logic [33:0] m_top [N_ENT];
   logic [9:0]  m_tag [N_ENT];
   logic        m_vld [N_ENT];

   // ------------------------------------------------------------------------
   // stimulus table with op 1 for a fill and op 0 for a fetch
   // ------------------------------------------------------------------------
   // way is unused on a fetch
   int tbl_op  [N_TBL] = '{1, 1, 1, 1, 0, 0, 0, 0, 0, 1, 0, 0};
   int tbl_idx [N_TBL] = '{0, 0, 3, 7, 0, 0, 3, 3, 7, 0, 0, 0};
   int tbl_way [N_TBL] = '{0, 1, 2, 3, 0, 0, 0, 0, 0, 1, 0, 0};
   // set 0 way 1 is refilled near the end and its old tag 'h022 then misses
   int tbl_tag [N_TBL] = '{'h011, 'h022, 'h033, 'h044, 'h011, 'h022,
                           'h033, 'h099, 'h044, 'h055, 'h022, 'h055};

   icache_top #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) u_icache_top (
      .rclk(rclk), .reset(reset),
      .fill_valid(fill_valid), .fill_index(fill_index), .fill_way(fill_way),
      .fill_tag(fill_tag), .fill_fet(fill_fet), .fill_top(fill_top),
      .fetch_req(fetch_req), .fetch_index(fetch_index), .fetch_tag(fetch_tag),
      .diag_start(diag_start),
      .fetch_valid(fetch_valid), .fetch_hit(fetch_hit),
      .fetch_fet(fetch_fet), .fetch_top(fetch_top),
      .diag_valid(diag_valid), .diag_data(diag_data),
      .diag_done(diag_done), .diag_busy(diag_busy)
   );

   initial rclk = 1'b0;
   always #5 rclk = ~rclk;

   // inputs change and outputs are sampled 1 ns after the edge
   task automatic next_cycle();
      @(posedge rclk);
      #1;
   endtask

   task automatic check_equal(input logic [67:0] act, input logic [67:0] exp,
                              input string what);
      if (act !== exp) begin
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, act, exp);
         $display("Simulation finished: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic fill_entry(input int idx, input int way, input int tag);
      logic [63:0] rnd_fet;
      logic [63:0] rnd_top;
      rnd_fet    = {$urandom(), $urandom()};
      rnd_top    = {$urandom(), $urandom()};
      fill_valid = 1'b1;
      fill_index = INDEX_W'(idx);
      fill_way   = 2'(way);
      fill_tag   = TAG_W'(tag);
      fill_fet   = rnd_fet[33:0];
      fill_top   = rnd_top[33:0];
      m_fet[idx*4+way] = rnd_fet[33:0];
      m_top[idx*4+way] = rnd_top[33:0];
      m_tag[idx*4+way] = TAG_W'(tag);
      m_vld[idx*4+way] = 1'b1;
      next_cycle();
      fill_valid = 1'b0;
   endtask

   task automatic fetch_and_check(input int idx, input int tag);
      logic [33:0] exp_fet;
      logic [33:0] exp_top;
      logic        exp_hit;
      exp_fet = '0;
      exp_top = '0;
      exp_hit = 1'b0;
      // hit only on a valid way whose tag matches
      for (int w = 0; w < 4; w++) begin
         if (m_vld[idx*4+w] && m_tag[idx*4+w] == TAG_W'(tag)) begin
            exp_hit = 1'b1;
            exp_fet = m_fet[idx*4+w];
            exp_top = m_top[idx*4+w];
         end
      end
      fetch_req   = 1'b1;
      fetch_index = INDEX_W'(idx);
      fetch_tag   = TAG_W'(tag);
      next_cycle();
      fetch_req = 1'b0;
      check_equal(68'(fetch_valid), 68'(1), "fetch_valid one cycle after strobe");
      check_equal(68'(fetch_hit), 68'(exp_hit), "fetch_hit");
      check_equal(68'(fetch_fet), 68'(exp_fet), "fetch_fet");
      check_equal(68'(fetch_top), 68'(exp_top), "fetch_top");
   endtask

   // ------------------------------------------------------------------------
   // diagnostic walk in set major order with way minor
   // ------------------------------------------------------------------------
   task automatic run_walk();
      int          cycles;
      int          words;
      bit          done;
      logic [33:0] f;
      logic [33:0] t;
      cycles     = 0;
      words      = 0;
      done       = 1'b0;
      diag_start = 1'b1;
      next_cycle();
      diag_start = 1'b0;
      while (!done && cycles < 100) begin
         next_cycle();
         cycles++;
         // stray fetch and second start mid walk are both dropped
         fetch_req  = (cycles == 5);
         diag_start = (cycles == 5);
         check_equal(68'(fetch_valid), 68'(0), "fetch_valid during walk");
         check_equal(68'(diag_busy), 68'(1), "diag_busy during walk");
         if (diag_valid) begin
            f = m_fet[words];
            t = m_top[words];
            check_equal(diag_data, {t[33:32], f[33:32], t[31:0], f[31:0]}, "diag_data");
            words++;
         end
         if (diag_done) begin
            // done rides on the last word
            check_equal(68'(diag_valid), 68'(1), "diag_valid with diag_done");
            check_equal(68'(words), 68'(32), "word count at diag_done");
            done = 1'b1;
         end
      end
      if (!done) begin
         $display("diag_done did not arrive within 100 cycles of diag_start");
         $display("Simulation finished: FAIL");
         $fatal(1, "walk timeout");
      end
      // nothing more may follow
      for (int i = 0; i < 40; i++) begin
         next_cycle();
         check_equal(68'(diag_valid), 68'(0), "diag_valid after walk");
         check_equal(68'(diag_done), 68'(0), "diag_done after walk");
         check_equal(68'(diag_busy), 68'(0), "diag_busy after walk");
      end
   endtask

   initial begin
      void'($urandom(32'hd94c));
      reset       = 1'b1;
      fill_valid  = 1'b0;
      fill_index  = '0;
      fill_way    = '0;
      fill_tag    = '0;
      fill_fet    = '0;
      fill_top    = '0;
      fetch_req   = 1'b0;
      fetch_index = '0;
      fetch_tag   = '0;
      diag_start  = 1'b0;
      for (int e = 0; e < N_ENT; e++) m_vld[e] = 1'b0;
      repeat (10) @(posedge rclk);
      #1;
      reset = 1'b0;
      check_equal(68'({fetch_valid, diag_valid, diag_done, diag_busy}), 68'(0),
                  "status after reset");
      // every set misses out of reset
      for (int s = 0; s < 8; s++) fetch_and_check(s, s * 3);
      for (int i = 0; i < N_TBL; i++) begin
         if (tbl_op[i] == 1) fill_entry(tbl_idx[i], tbl_way[i], tbl_tag[i]);
         else fetch_and_check(tbl_idx[i], tbl_tag[i]);
      end
      // known contents everywhere before the walk
      for (int e = 0; e < N_ENT; e++) fill_entry(e / 4, e % 4, 'h100 + e);
      run_walk();
      fetch_and_check(5, 'h116);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

//--- icache_top.sv
// fetch results are valid only with fetch_valid; diag_data only with diag_valid
`timescale 1ns/1ps

module icache_top #(
   parameter int INDEX_W = 3,
   parameter int TAG_W   = 10
) (
   input  logic                             rclk,
   input  logic                             reset,
   input  logic                             fill_valid,
   input  logic [INDEX_W-1:0]               fill_index,
   input  logic [icache_pkg::WAY_SEL_W-1:0] fill_way,
   input  logic [TAG_W-1:0]                 fill_tag,
   input  logic [icache_pkg::WAY_W-1:0]     fill_fet,
   input  logic [icache_pkg::WAY_W-1:0]     fill_top,
   input  logic                             fetch_req,
   input  logic [INDEX_W-1:0]               fetch_index,
   input  logic [TAG_W-1:0]                 fetch_tag,
   input  logic                             diag_start,
   output logic                             fetch_valid,
   output logic                             fetch_hit,
   output logic [icache_pkg::WAY_W-1:0]     fetch_fet,
   output logic [icache_pkg::WAY_W-1:0]     fetch_top,
   output logic                             diag_valid,
   output logic [icache_pkg::DIAG_W-1:0]    diag_data,
   output logic                             diag_done,
   output logic                             diag_busy
);

   logic                             array_rd;
   logic [INDEX_W-1:0]               array_index;
   logic                             lookup_en;
   logic [icache_pkg::SET_W-1:0]     set_fet;
   logic [icache_pkg::SET_W-1:0]     set_top;
   logic [icache_pkg::NUM_WAYS-1:0]  waysel;
   logic                             diag_rd;
   logic [icache_pkg::WAY_SEL_W-1:0] diag_way;
   logic [INDEX_W-1:0]               cnt_index;
   logic [icache_pkg::WAY_SEL_W-1:0] cnt_way;
   logic                             cnt_last;
   logic                             cnt_clear;
   logic                             cnt_step;

   // ------------------------------------------------------------------------
   // control
   // ------------------------------------------------------------------------

   icache_diag_ctrl #(.INDEX_W(INDEX_W)) u_diag_ctrl (
      .rclk(rclk), .reset(reset),
      .fetch_req(fetch_req), .fetch_index(fetch_index), .diag_start(diag_start),
      .cnt_index(cnt_index), .cnt_way(cnt_way), .cnt_last(cnt_last),
      .array_rd(array_rd), .array_index(array_index), .lookup_en(lookup_en),
      .diag_rd(diag_rd), .diag_way(diag_way),
      .cnt_clear(cnt_clear), .cnt_step(cnt_step),
      .diag_busy(diag_busy), .diag_done(diag_done)
   );

   icache_diag_counter #(.INDEX_W(INDEX_W)) u_diag_counter (
      .rclk(rclk), .reset(reset),
      .cnt_clear(cnt_clear), .cnt_step(cnt_step),
      .cnt_index(cnt_index), .cnt_way(cnt_way), .cnt_last(cnt_last)
   );

   // ------------------------------------------------------------------------
   // arrays and way select
   // ------------------------------------------------------------------------

   icache_data_array #(.INDEX_W(INDEX_W)) u_data_array (
      .rclk(rclk), .reset(reset),
      .fill_valid(fill_valid), .fill_index(fill_index), .fill_way(fill_way),
      .fill_fet(fill_fet), .fill_top(fill_top),
      .array_rd(array_rd), .array_index(array_index),
      .set_fet(set_fet), .set_top(set_top)
   );

   // tag lookup shares the array index, so fetch and data stay aligned
   icache_tag_match #(.INDEX_W(INDEX_W), .TAG_W(TAG_W)) u_tag_match (
      .rclk(rclk), .reset(reset),
      .fill_valid(fill_valid), .fill_index(fill_index), .fill_way(fill_way),
      .fill_tag(fill_tag),
      .lookup_en(lookup_en), .lookup_index(array_index), .lookup_tag(fetch_tag),
      .waysel(waysel), .hit(fetch_hit), .lookup_valid(fetch_valid)
   );

   icache_way_select u_way_select (
      .rclk(rclk), .reset(reset),
      .set_fet(set_fet), .set_top(set_top), .waysel(waysel),
      .diag_rd(diag_rd), .diag_way(diag_way),
      .fetch_fet(fetch_fet), .fetch_top(fetch_top),
      .diag_data(diag_data), .diag_valid(diag_valid)
   );

endmodule

//--- icache_diag_ctrl.sv
// strobes are single cycle; fetch_req and diag_start arriving while busy are dropped without notice
`timescale 1ns/1ps

module icache_diag_ctrl #(
   parameter int INDEX_W = 3
) (
   input  logic                             rclk,
   input  logic                             reset,
   input  logic                             fetch_req,
   input  logic [INDEX_W-1:0]               fetch_index,
   input  logic                             diag_start,
   input  logic [INDEX_W-1:0]               cnt_index,
   input  logic [icache_pkg::WAY_SEL_W-1:0] cnt_way,
   input  logic                             cnt_last,
   output logic                             array_rd,
   output logic [INDEX_W-1:0]               array_index,
   output logic                             lookup_en,
   output logic                             diag_rd,
   output logic [icache_pkg::WAY_SEL_W-1:0] diag_way,
   output logic                             cnt_clear,
   output logic                             cnt_step,
   output logic                             diag_busy,
   output logic                             diag_done
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_WALK  = 2'd1;
   localparam logic [1:0] ST_DRAIN = 2'd2;

   logic [1:0] state;
   logic [1:0] state_nxt;

   // ------------------------------------------------------------------------
   // state register
   // ------------------------------------------------------------------------

   always_ff @(posedge rclk) begin
      if (reset) state <= ST_IDLE;
      else       state <= state_nxt;
   end

   // ------------------------------------------------------------------------
   // next state and array arbitration
   // ------------------------------------------------------------------------

   always_comb begin
      state_nxt   = state;
      array_rd    = 1'b0;
      array_index = fetch_index;
      lookup_en   = 1'b0;
      diag_rd     = 1'b0;
      diag_way    = cnt_way;
      cnt_clear   = 1'b0;
      cnt_step    = 1'b0;
      diag_done   = 1'b0;
      case (state)
         ST_IDLE: begin
            // fetch owns the array here
            array_rd  = fetch_req;
            lookup_en = fetch_req;
            // walk begins next cycle, so a same-cycle fetch never collides
            if (diag_start) begin
               cnt_clear = 1'b1;
               state_nxt = ST_WALK;
            end
         end
         ST_WALK: begin
            // one read per cycle, way fastest
            array_rd    = 1'b1;
            array_index = cnt_index;
            diag_rd     = 1'b1;
            cnt_step    = 1'b1;
            if (cnt_last) state_nxt = ST_DRAIN;
         end
         ST_DRAIN: begin
            // last word is on diag_data this cycle
            diag_done = 1'b1;
            state_nxt = ST_IDLE;
         end
         default: state_nxt = ST_IDLE;
      endcase
   end

   assign diag_busy = (state != ST_IDLE);

endmodule

//--- icache_diag_counter.sv
// way count wraps at NUM_WAYS only because NUM_WAYS equals 2**WAY_SEL_W
`timescale 1ns/1ps

module icache_diag_counter #(
   parameter int INDEX_W = 3
) (
   input  logic                             rclk,
   input  logic                             reset,
   input  logic                             cnt_clear,
   input  logic                             cnt_step,
   output logic [INDEX_W-1:0]               cnt_index,
   output logic [icache_pkg::WAY_SEL_W-1:0] cnt_way,
   output logic                             cnt_last
);

   // set in the high bits, way in the low bits
   // one increment steps the way, carry steps the set
   always_ff @(posedge rclk) begin
      if (reset || cnt_clear) begin
         cnt_index <= '0;
         cnt_way   <= '0;
      end else if (cnt_step) begin
         {cnt_index, cnt_way} <= {cnt_index, cnt_way} + 1'b1;
      end
   end

   // final set, final way
   assign cnt_last = &{cnt_index, cnt_way};

endmodule

//--- icache_way_select.sv
// waysel must be one-hot or zero; more than one hot way ORs the ways together
`timescale 1ns/1ps

module icache_way_select (
   input  logic                              rclk,
   input  logic                              reset,
   input  logic [icache_pkg::SET_W-1:0]      set_fet,
   input  logic [icache_pkg::SET_W-1:0]      set_top,
   input  logic [icache_pkg::NUM_WAYS-1:0]   waysel,
   input  logic                              diag_rd,
   input  logic [icache_pkg::WAY_SEL_W-1:0]  diag_way,
   output logic [icache_pkg::WAY_W-1:0]      fetch_fet,
   output logic [icache_pkg::WAY_W-1:0]      fetch_top,
   output logic [icache_pkg::DIAG_W-1:0]     diag_data,
   output logic                              diag_valid
);

   localparam int WAY_W  = icache_pkg::WAY_W;
   localparam int DATA_W = icache_pkg::DATA_W;

   logic [icache_pkg::WAY_SEL_W-1:0] diag_way_s;
   logic [icache_pkg::NUM_WAYS-1:0]  dec_way_s;
   logic [WAY_W-1:0]                 diag_fet_s;
   logic [WAY_W-1:0]                 diag_top_s;

   // and-or over the four ways, zero select gives zero
   function automatic logic [WAY_W-1:0] ao_mux(input logic [icache_pkg::SET_W-1:0] ways,
                                               input logic [icache_pkg::NUM_WAYS-1:0] sel);
      logic [WAY_W-1:0] acc;
      acc = '0;
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
         acc = acc | (ways[w*WAY_W +: WAY_W] & {WAY_W{sel[w]}});
      end
      return acc;
   endfunction

   // ------------------------------------------------------------------------
   // fetch path, timing critical
   // ------------------------------------------------------------------------

   // straight from tag compare, no decode in the path
   assign fetch_fet = ao_mux(set_fet, waysel);
   assign fetch_top = ao_mux(set_top, waysel);

   // ------------------------------------------------------------------------
   // diagnostic path
   // ------------------------------------------------------------------------

   // way number rides alongside the array read
   always_ff @(posedge rclk) begin
      if (diag_rd) diag_way_s <= diag_way;
   end

   always_ff @(posedge rclk) begin
      if (reset) diag_valid <= 1'b0;
      else       diag_valid <= diag_rd;
   end

   // binary to one-hot
   assign dec_way_s  = icache_pkg::NUM_WAYS'(1) << diag_way_s;
   assign diag_fet_s = ao_mux(set_fet, dec_way_s);
   assign diag_top_s = ao_mux(set_top, dec_way_s);

   // predecode bits on top, then instruction bits
   assign diag_data = {diag_top_s[WAY_W-1:DATA_W], diag_fet_s[WAY_W-1:DATA_W],
                       diag_top_s[DATA_W-1:0],     diag_fet_s[DATA_W-1:0]};

endmodule

//--- icache_tag_match.sv
// tags must be unique within a set or waysel is not one-hot; no replacement, fills name the way
`timescale 1ns/1ps

module icache_tag_match #(
   parameter int INDEX_W = 3,
   parameter int TAG_W   = 10
) (
   input  logic                             rclk,
   input  logic                             reset,
   input  logic                             fill_valid,
   input  logic [INDEX_W-1:0]               fill_index,
   input  logic [icache_pkg::WAY_SEL_W-1:0] fill_way,
   input  logic [TAG_W-1:0]                 fill_tag,
   input  logic                             lookup_en,
   input  logic [INDEX_W-1:0]               lookup_index,
   input  logic [TAG_W-1:0]                 lookup_tag,
   output logic [icache_pkg::NUM_WAYS-1:0]  waysel,
   output logic                             hit,
   output logic                             lookup_valid
);

   localparam int NUM_SETS = 1 << INDEX_W;

   logic [TAG_W-1:0]                tag_mem [NUM_SETS][icache_pkg::NUM_WAYS];
   logic [icache_pkg::NUM_WAYS-1:0] valid_bits [NUM_SETS];
   logic [icache_pkg::NUM_WAYS-1:0] match;

   // tag storage, payload only
   always_ff @(posedge rclk) begin
      if (fill_valid) tag_mem[fill_index][fill_way] <= fill_tag;
   end

   // valid bits, all clear out of reset so every lookup misses
   always_ff @(posedge rclk) begin
      if (reset) begin
         for (int s = 0; s < NUM_SETS; s++) valid_bits[s] <= '0;
      end else if (fill_valid) begin
         valid_bits[fill_index][fill_way] <= 1'b1;
      end
   end

   // compare all ways of the looked-up set in parallel
   always_comb begin
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
         match[w] = valid_bits[lookup_index][w] && (tag_mem[lookup_index][w] == lookup_tag);
      end
   end

   // s1 way select; zero when no lookup so the and-or mux gives zeros
   always_ff @(posedge rclk) begin
      if (reset) begin
         waysel       <= '0;
         hit          <= 1'b0;
         lookup_valid <= 1'b0;
      end else begin
         waysel       <= lookup_en ? match : '0;
         hit          <= lookup_en & (|match);
         lookup_valid <= lookup_en;
      end
   end

endmodule

//--- icache_data_array.sv
// behavioral storage, no memory macro; a fill and a read of the same entry in one cycle sees old data
`timescale 1ns/1ps

module icache_data_array #(
   parameter int INDEX_W = 3
) (
   input  logic                            rclk,
   input  logic                            reset,
   // fill port, one way of one set
   input  logic                            fill_valid,
   input  logic [INDEX_W-1:0]              fill_index,
   input  logic [icache_pkg::WAY_SEL_W-1:0] fill_way,
   input  logic [icache_pkg::WAY_W-1:0]    fill_fet,
   input  logic [icache_pkg::WAY_W-1:0]    fill_top,
   // read port, whole set
   input  logic                            array_rd,
   input  logic [INDEX_W-1:0]              array_index,
   output logic [icache_pkg::SET_W-1:0]    set_fet,
   output logic [icache_pkg::SET_W-1:0]    set_top
);

   localparam int NUM_SETS = 1 << INDEX_W;
   localparam int WAY_W    = icache_pkg::WAY_W;

   // one row per set, four ways packed side by side
   logic [icache_pkg::SET_W-1:0] fet_mem [NUM_SETS];
   logic [icache_pkg::SET_W-1:0] top_mem [NUM_SETS];

   // ------------------------------------------------------------------------
   // fill write
   // ------------------------------------------------------------------------

   // only the addressed way slice changes
   always_ff @(posedge rclk) begin
      if (fill_valid) begin
         fet_mem[fill_index][fill_way*WAY_W +: WAY_W] <= fill_fet;
         top_mem[fill_index][fill_way*WAY_W +: WAY_W] <= fill_top;
      end
   end

   // ------------------------------------------------------------------------
   // s1 read stage
   // ------------------------------------------------------------------------

   // all four ways come out together, way select happens downstream
   // cleared on reset so the way muxes see zeros before the first read
   always_ff @(posedge rclk) begin
      if (reset) begin
         set_fet <= '0;
         set_top <= '0;
      end else if (array_rd) begin
         set_fet <= fet_mem[array_index];
         set_top <= top_mem[array_index];
      end
   end

endmodule

//--- icache_pkg.sv
// geometry is fixed at four ways of 34-bit words; set count and tag width are module parameters
package icache_pkg;

   // -------------------------------------------------------------------------
   // way geometry
   // -------------------------------------------------------------------------

   // one-hot way select is four bits, so this stays at 4
   localparam int NUM_WAYS = 4;

   // binary way number for fills and the diagnostic walk
   localparam int WAY_SEL_W = 2;

   // -------------------------------------------------------------------------
   // word widths
   // -------------------------------------------------------------------------

   // instruction bits per fetch/top word
   localparam int DATA_W = 32;

   // predecode bits above the instruction bits
   localparam int PDEC_W = 2;

   // one fetch or top word as stored per way
   localparam int WAY_W = DATA_W + PDEC_W;

   // a whole set read out side by side, way 0 in the low bits
   localparam int SET_W = NUM_WAYS * WAY_W;

   // packed word for bist and error logic
   // {top[33:32], fet[33:32], top[31:0], fet[31:0]}
   localparam int DIAG_W = 2 * WAY_W;

endpackage
